// ==== include/fetch_config.svh ====
// Fetch subsystem configuration
// Bus, byte count and register widths shared by every block

`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// AXI read address width, 16 GB space
`define FETCH_ADDR_WIDTH 34

// AXI read data width, one 64-byte beat
`define FETCH_DATA_WIDTH 512

// Byte count width, requests below 1 MB
`define FETCH_COUNT_WIDTH 20

// Beat count width, count / 64 rounded up
`define FETCH_BEAT_WIDTH (`FETCH_COUNT_WIDTH - 5)

// Register port data width
`define FETCH_REG_WIDTH 32

`endif

// ==== hdl/fetch_axi_pkg.sv ====
// Fetch AXI package
// Response codes and beat geometry of the 512-bit read bus

package fetch_axi_pkg;

  // --------------------------------------------------
  // Read response codes
  // --------------------------------------------------
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  // Bytes moved per 512-bit beat
  localparam int unsigned BEAT_BYTES = 64;

  // Beats in one 4 KB page
  localparam int unsigned BOUNDARY_BEATS = 64;

endpackage

// ==== hdl/fetch_ctrl_pkg.sv ====
// Fetch control package
// Read master states and the register map

package fetch_ctrl_pkg;

  // Read master FSM states
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    AR   = 2'd1,
    R    = 2'd2
  } fetch_state_e;

  // --------------------------------------------------
  // Register map, word addresses
  // --------------------------------------------------
  typedef enum logic [3:0] {
    CTRL     = 4'd0,
    ADDR_LO  = 4'd1,
    ADDR_HI  = 4'd2,
    COUNT    = 4'd3,
    STATUS   = 4'd4,
    CHECKSUM = 4'd5,
    BEATS    = 4'd6
  } reg_addr_e;

endpackage

// ==== hdl/fetch_if.sv ====
// Fetch request and response interfaces
// Request carries one bulk read, response carries returned beats

`timescale 1ns/100ps
`include "fetch_config.svh"

interface fetch_req_if;

  logic                          valid;
  logic                          ready;
  logic [`FETCH_ADDR_WIDTH-1:0]  start_address;
  logic [`FETCH_COUNT_WIDTH-1:0] byte_count;

  // Register block side
  modport initiator (output valid, start_address, byte_count, input ready);

  // Read master side
  modport target (input valid, start_address, byte_count, output ready);

endinterface

interface fetch_resp_if
  import fetch_axi_pkg::*;
;

  logic                         valid;
  logic                         ready;
  logic                         last;
  logic [`FETCH_DATA_WIDTH-1:0] data;
  axi_resp_e                    resp;

  // Read master side
  modport source (output valid, last, data, resp, input ready);

  // Checksum side
  modport sink (input valid, last, data, resp, output ready);

endinterface

// ==== hdl/axi_read_master.sv ====
// AXI read master
// Splits one fetch request into bursts that stay inside 4 KB pages,
// issues every burst first and then streams the read beats onward

`timescale 1ns/100ps
`include "fetch_config.svh"

module axi_read_master
  import fetch_axi_pkg::*;
  import fetch_ctrl_pkg::*;
(
  input  logic                         core_clk,
  input  logic                         resetn,
  fetch_req_if.target                  req,
  fetch_resp_if.source                 resp,
  output logic [`FETCH_ADDR_WIDTH-1:0] axi_araddr,
  output logic [7:0]                   axi_arlen,
  output logic                         axi_arvalid,
  input  logic                         axi_arready,
  input  logic [`FETCH_DATA_WIDTH-1:0] axi_rdata,
  input  logic                         axi_rlast,
  input  logic                         axi_rvalid,
  input  axi_resp_e                    axi_rresp,
  output logic                         axi_rready
);

  localparam int ADDR_W = `FETCH_ADDR_WIDTH;
  localparam int BEAT_W = `FETCH_BEAT_WIDTH;

  fetch_state_e state, state_n;

  logic [ADDR_W-1:0] cur_addr;
  logic [BEAT_W-1:0] req_beats;
  logic [BEAT_W-1:0] total_beats;
  logic [BEAT_W-1:0] beats_requested;
  logic [BEAT_W-1:0] beats_received;
  logic [BEAT_W-1:0] remaining;
  logic [6:0]        boundary_beats;
  logic [6:0]        burst_beats;
  logic              req_hs;
  logic              ar_hs;
  logic              r_hs;
  logic              last_burst;
  logic              last_beat;

  assign req_hs = req.valid && req.ready;
  assign ar_hs  = axi_arvalid && axi_arready;
  assign r_hs   = resp.valid && resp.ready;

  // Byte count / 64, rounded up
  assign req_beats = {1'b0, req.byte_count[`FETCH_COUNT_WIDTH-1:6]} +
                     BEAT_W'(|req.byte_count[5:0]);

  // --------------------------------------------------
  // Burst sizing
  // --------------------------------------------------
  assign remaining = total_beats - beats_requested;

  // Beats left before the next 4 KB page, 1 to 64
  assign boundary_beats = 7'(BOUNDARY_BEATS) - {1'b0, cur_addr[11:6]};

  always_comb begin
    if (remaining < BEAT_W'(boundary_beats)) begin
      burst_beats = remaining[6:0];
    end else begin
      burst_beats = boundary_beats;
    end
  end

  assign last_burst = (remaining == BEAT_W'(burst_beats));
  assign last_beat  = (beats_received == total_beats - 1'b1);

  // Request payload, low six address bits dropped
  always_ff @(posedge core_clk) begin
    if (req_hs) begin
      cur_addr    <= {req.start_address[ADDR_W-1:6], 6'b0};
      total_beats <= req_beats;
    end else if (ar_hs) begin
      cur_addr <= cur_addr + ADDR_W'(burst_beats) * ADDR_W'(BEAT_BYTES);
    end
  end

  // Progress counters, cleared per request
  always_ff @(posedge core_clk or negedge resetn) begin
    if (!resetn) begin
      state           <= IDLE;
      beats_requested <= '0;
      beats_received  <= '0;
    end else begin
      state <= state_n;
      if (req_hs) begin
        beats_requested <= '0;
        beats_received  <= '0;
      end else begin
        if (ar_hs)
          beats_requested <= beats_requested + BEAT_W'(burst_beats);
        if (r_hs)
          beats_received <= beats_received + 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // FSM
  // --------------------------------------------------
  always_comb begin
    state_n = state;
    case (state)
      IDLE:    state_n = req_hs ? AR : IDLE;
      // All bursts go out before any data is taken
      AR:      state_n = (ar_hs && last_burst) ? R : AR;
      R:       state_n = (r_hs && last_beat) ? IDLE : R;
      default: state_n = IDLE;
    endcase
  end

  // AXI address channel, held steady while arready is low
  assign axi_arvalid = (state == AR);
  assign axi_araddr  = cur_addr;
  assign axi_arlen   = {1'b0, burst_beats - 7'd1};

  // Data path is a straight pass in state R
  assign axi_rready = (state == R) && resp.ready;
  assign req.ready  = (state == IDLE);
  assign resp.valid = (state == R) && axi_rvalid;
  // Only the closing rlast of the whole fetch is marked
  assign resp.last  = (state == R) && axi_rvalid && axi_rlast && last_beat;
  assign resp.data  = axi_rdata;
  assign resp.resp  = axi_rresp;

endmodule

// ==== hdl/fetch_regs.sv ====
// Fetch register block
// Holds address and count, launches fetches and reports status

`timescale 1ns/100ps
`include "fetch_config.svh"

module fetch_regs
  import fetch_ctrl_pkg::*;
(
  input  logic                          core_clk,
  input  logic                          resetn,
  input  logic                          reg_wr_en,
  input  logic                          reg_rd_en,
  input  reg_addr_e                     reg_addr,
  input  logic [`FETCH_REG_WIDTH-1:0]   reg_wdata,
  output logic [`FETCH_REG_WIDTH-1:0]   reg_rdata,
  fetch_req_if.initiator                req,
  output logic                          sum_clear,
  input  logic                          sum_done,
  input  logic [31:0]                   sum_value,
  input  logic [`FETCH_BEAT_WIDTH-1:0]  sum_beats,
  input  logic                          sum_error
);

  localparam int REG_W = `FETCH_REG_WIDTH;
  localparam int HI_W  = `FETCH_ADDR_WIDTH - `FETCH_REG_WIDTH;

  logic [REG_W-1:0]              addr_lo;
  logic [HI_W-1:0]               addr_hi;
  logic [`FETCH_COUNT_WIDTH-1:0] byte_count;
  logic                          busy;
  logic                          done;
  logic                          start;
  logic                          count_zero;

  // Start bit ignored while a fetch runs
  assign start      = reg_wr_en && (reg_addr == CTRL) && reg_wdata[0] && !busy;
  assign count_zero = (byte_count == '0);

  // --------------------------------------------------
  // Configuration and control state
  // --------------------------------------------------
  always_ff @(posedge core_clk or negedge resetn) begin
    if (!resetn) begin
      addr_lo    <= '0;
      addr_hi    <= '0;
      byte_count <= '0;
      busy       <= 1'b0;
      done       <= 1'b0;
      req.valid  <= 1'b0;
      sum_clear  <= 1'b0;
    end else begin
      if (reg_wr_en && reg_addr == ADDR_LO) addr_lo <= reg_wdata;
      if (reg_wr_en && reg_addr == ADDR_HI) addr_hi <= reg_wdata[HI_W-1:0];
      if (reg_wr_en && reg_addr == COUNT) byte_count <= reg_wdata[`FETCH_COUNT_WIDTH-1:0];
      sum_clear <= start;
      if (start) begin
        // Zero count completes without touching the bus
        busy      <= !count_zero;
        done      <= count_zero;
        req.valid <= !count_zero;
      end else begin
        if (req.valid && req.ready)
          req.valid <= 1'b0;
        if (sum_done) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  assign req.start_address = {addr_hi, addr_lo};
  assign req.byte_count    = byte_count;

  // Read data one cycle after the strobe
  always_ff @(posedge core_clk) begin
    if (reg_rd_en) begin
      case (reg_addr)
        ADDR_LO:  reg_rdata <= addr_lo;
        ADDR_HI:  reg_rdata <= REG_W'(addr_hi);
        COUNT:    reg_rdata <= REG_W'(byte_count);
        STATUS:   reg_rdata <= REG_W'({sum_error, done, busy});
        CHECKSUM: reg_rdata <= sum_value;
        BEATS:    reg_rdata <= REG_W'(sum_beats);
        default:  reg_rdata <= '0;
      endcase
    end
  end

endmodule

// ==== hdl/fetch_checksum.sv ====
// Fetch checksum unit
// XOR fold of every returned beat, beat count and sticky error flag

`timescale 1ns/100ps
`include "fetch_config.svh"

module fetch_checksum
  import fetch_axi_pkg::*;
(
  input  logic                         core_clk,
  input  logic                         resetn,
  fetch_resp_if.sink                   resp,
  input  logic                         clear,
  output logic                         done,
  output logic [31:0]                  checksum,
  output logic [`FETCH_BEAT_WIDTH-1:0] beats,
  output logic                         error
);

  localparam int WORDS = `FETCH_DATA_WIDTH / 32;

  logic        beat_hs;
  logic [31:0] beat_fold;

  // Never back-pressures the read master
  assign resp.ready = 1'b1;
  assign beat_hs    = resp.valid && resp.ready;
  assign done       = beat_hs && resp.last;

  // Sixteen words of one beat folded together
  always_comb begin
    beat_fold = '0;
    for (int w = 0; w < WORDS; w++)
      beat_fold = beat_fold ^ resp.data[w*32 +: 32];
  end

  always_ff @(posedge core_clk or negedge resetn) begin
    if (!resetn) begin
      checksum <= '0;
      beats    <= '0;
      error    <= 1'b0;
    end else if (clear) begin
      checksum <= '0;
      beats    <= '0;
      error    <= 1'b0;
    end else if (beat_hs) begin
      checksum <= checksum ^ beat_fold;
      beats    <= beats + 1'b1;
      // Sticky until the next launch
      if (resp.resp != OKAY)
        error <= 1'b1;
    end
  end

endmodule

// ==== hdl/fetch_subsystem.sv ====
// Fetch subsystem top level
// Register block, AXI read master and checksum unit

`timescale 1ns/100ps
`include "fetch_config.svh"

module fetch_subsystem
  import fetch_axi_pkg::*;
  import fetch_ctrl_pkg::*;
(
  input  logic                         core_clk,
  input  logic                         resetn,
  // Register port
  input  logic                         reg_wr_en,
  input  logic                         reg_rd_en,
  input  reg_addr_e                    reg_addr,
  input  logic [`FETCH_REG_WIDTH-1:0]  reg_wdata,
  output logic [`FETCH_REG_WIDTH-1:0]  reg_rdata,
  // AXI read address channel
  output logic [`FETCH_ADDR_WIDTH-1:0] axi_araddr,
  output logic [7:0]                   axi_arlen,
  output logic                         axi_arvalid,
  input  logic                         axi_arready,
  // AXI read data channel
  input  logic [`FETCH_DATA_WIDTH-1:0] axi_rdata,
  input  logic                         axi_rlast,
  input  logic                         axi_rvalid,
  input  axi_resp_e                    axi_rresp,
  output logic                         axi_rready
);

  logic                         sum_clear;
  logic                         sum_done;
  logic [31:0]                  sum_value;
  logic [`FETCH_BEAT_WIDTH-1:0] sum_beats;
  logic                         sum_error;

  fetch_req_if  req_if ();
  fetch_resp_if resp_if ();

  // --------------------------------------------------
  // Register block
  // --------------------------------------------------
  fetch_regs regs0 (
    .core_clk, .resetn, .reg_wr_en, .reg_rd_en, .reg_addr, .reg_wdata, .reg_rdata,
    .req(req_if.initiator), .sum_clear, .sum_done, .sum_value, .sum_beats, .sum_error
  );

  // Read master facing the AXI bus
  axi_read_master master0 (
    .core_clk, .resetn, .req(req_if.target), .resp(resp_if.source),
    .axi_araddr, .axi_arlen, .axi_arvalid, .axi_arready,
    .axi_rdata, .axi_rlast, .axi_rvalid, .axi_rresp, .axi_rready
  );

  // Checksum on the returned beats
  fetch_checksum checksum0 (
    .core_clk, .resetn, .resp(resp_if.sink), .clear(sum_clear),
    .done(sum_done), .checksum(sum_value), .beats(sum_beats), .error(sum_error)
  );

endmodule

// ==== verification/tb_clock_gen.sv ====
// Testbench clock and reset source
// core_clk free-running, resetn released a few cycles after start

`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 8
) (
  output logic core_clk,
  output logic resetn
);

  initial begin
    core_clk = 1'b0;
    forever #(PERIOD_NS / 2) core_clk = ~core_clk;
  end

  // Release just after an edge, like every other driven input
  initial begin
    resetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge core_clk);
    #1 resetn = 1'b1;
  end

endmodule

// ==== verification/tb_fetch_subsystem.sv ====
// Fetch subsystem testbench
// AXI slave memory model, register driver and reference model
// Random fetches with AR and R stalls, injected SLVERR beats

`timescale 1ns/100ps
`include "fetch_config.svh"

module tb_fetch_subsystem
  import fetch_axi_pkg::*;
  import fetch_ctrl_pkg::*;
();

  localparam int ADDR_W      = `FETCH_ADDR_WIDTH;
  localparam int DATA_W      = `FETCH_DATA_WIDTH;
  localparam int NUM_FETCHES = 20;
  localparam int MAX_BEATS   = 313;
  // Worst stalled fetch plus register traffic per fetch
  localparam int CYCLE_LIMIT = NUM_FETCHES * (MAX_BEATS * 6 + 50) + 100;

  logic                        core_clk;
  logic                        resetn;
  logic                        reg_wr_en;
  logic                        reg_rd_en;
  reg_addr_e                   reg_addr;
  logic [`FETCH_REG_WIDTH-1:0] reg_wdata;
  logic [`FETCH_REG_WIDTH-1:0] reg_rdata;
  logic [ADDR_W-1:0]           axi_araddr;
  logic [7:0]                  axi_arlen;
  logic                        axi_arvalid;
  logic                        axi_arready;
  logic [DATA_W-1:0]           axi_rdata;
  logic                        axi_rlast;
  logic                        axi_rvalid;
  axi_resp_e                   axi_rresp;
  logic                        axi_rready;

  logic [15:0] lfsr;
  int          cycles;
  int          mismatches;
  int          failures;
  string       test_name;

  // Reference model of the running fetch
  logic [ADDR_W-1:0] exp_addr_q[$];
  int                exp_len_q[$];
  logic [31:0]       exp_checksum;
  int                exp_beats;
  logic              exp_error;
  int                ar_beat_total;
  logic              arvalid_seen;

  // Slave side state
  logic [ADDR_W-1:0] slv_addr_q[$];
  int                slv_len_q[$];
  int                beat_idx;
  logic              beat_shown;
  logic              r_hs_seen;
  logic              ar_low_seen;
  logic              ar_stalled;
  logic              inject_errors;
  logic [ADDR_W-1:0] held_addr;
  logic [7:0]        held_len;

  tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(8)) clk0 (.core_clk, .resetn);

  fetch_subsystem dut0 (
    .core_clk, .resetn, .reg_wr_en, .reg_rd_en, .reg_addr, .reg_wdata, .reg_rdata,
    .axi_araddr, .axi_arlen, .axi_arvalid, .axi_arready,
    .axi_rdata, .axi_rlast, .axi_rvalid, .axi_rresp, .axi_rready
  );

  // --------------------------------------------------
  // Random bits from x^16 + x^14 + x^13 + x^11 + 1
  // --------------------------------------------------
  function automatic int unsigned rand_bits(input int n);
    int unsigned v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      v    = (v << 1) | int'(lfsr[0]);
    end
    return v;
  endfunction

  // Aligned address now and then parked near a page end
  function automatic logic [ADDR_W-1:0] random_address();
    logic [ADDR_W-1:0] a;
    a = {28'(rand_bits(28)), 6'b0};
    if (rand_bits(2) == 0)
      a[11:6] = 6'(63 - rand_bits(3));
    return a;
  endfunction

  // Word w of the beat at address a holds a + w
  function automatic logic [DATA_W-1:0] beat_data(input logic [ADDR_W-1:0] addr);
    logic [DATA_W-1:0] d;
    for (int w = 0; w < DATA_W / 32; w++)
      d[w*32 +: 32] = addr[31:0] + 32'(w);
    return d;
  endfunction

  function automatic logic [31:0] word_fold(input logic [ADDR_W-1:0] addr);
    logic [31:0] f;
    f = '0;
    for (int w = 0; w < DATA_W / 32; w++)
      f = f ^ (addr[31:0] + 32'(w));
    return f;
  endfunction

  task automatic report_mismatch(input string field, input logic [63:0] expected,
                                 input logic [63:0] actual);
    $display("mismatch %s %s: expected 0x%0h, actual 0x%0h", test_name, field,
             expected, actual);
    mismatches++;
  endtask

  task automatic report_failure(input string what);
    $display("error in %s: %s", test_name, what);
    failures++;
  endtask

  // Expected bursts, fold and beat total for one request
  task automatic load_model(input logic [ADDR_W-1:0] base, input int count);
    logic [ADDR_W-1:0] addr;
    int remaining;
    int room;
    int n;
    addr         = {base[ADDR_W-1:6], 6'b0};
    remaining    = (count + 63) / 64;
    exp_beats    = remaining;
    exp_checksum = '0;
    for (int i = 0; i < remaining; i++)
      exp_checksum = exp_checksum ^ word_fold(addr + ADDR_W'(i * 64));
    exp_addr_q.delete();
    exp_len_q.delete();
    while (remaining > 0) begin
      // Never past the next 4 KB page
      room = 64 - int'(addr[11:6]);
      n    = (remaining < room) ? remaining : room;
      exp_addr_q.push_back(addr);
      exp_len_q.push_back(n - 1);
      addr      = addr + ADDR_W'(n * 64);
      remaining = remaining - n;
    end
    exp_error     = 1'b0;
    ar_beat_total = 0;
    arvalid_seen  = 1'b0;
  endtask

  // --------------------------------------------------
  // Bus monitor sampled mid-cycle
  // --------------------------------------------------
  task automatic watch_bus();
    logic [ADDR_W-1:0] e_addr;
    int                e_len;
    logic              rready_exp;
    if (axi_arvalid)
      arvalid_seen = 1'b1;
    // rready only once all bursts are out and beats remain
    rready_exp = (exp_addr_q.size() == 0) && (slv_addr_q.size() > 0);
    if (axi_rready !== rready_exp)
      report_mismatch("rready", rready_exp, axi_rready);
    if (ar_stalled && axi_arvalid && axi_araddr !== held_addr)
      report_mismatch("held araddr", held_addr, axi_araddr);
    if (ar_stalled && axi_arvalid && axi_arlen !== held_len)
      report_mismatch("held arlen", held_len, axi_arlen);
    ar_stalled = axi_arvalid && !axi_arready;
    held_addr  = axi_araddr;
    held_len   = axi_arlen;
    if (axi_arvalid && axi_arready) begin
      if (exp_addr_q.size() == 0) begin
        report_failure($sformatf("unexpected AR burst at 0x%0h", axi_araddr));
      end else begin
        e_addr = exp_addr_q.pop_front();
        e_len  = exp_len_q.pop_front();
        if (axi_araddr !== e_addr)
          report_mismatch("araddr", e_addr, axi_araddr);
        if (int'(axi_arlen) != e_len)
          report_mismatch("arlen", e_len, axi_arlen);
      end
      if (int'(axi_araddr[11:6]) + int'(axi_arlen) > 63)
        report_failure($sformatf("burst at 0x%0h crosses a 4 KB page", axi_araddr));
      ar_beat_total += int'(axi_arlen) + 1;
      slv_addr_q.push_back(axi_araddr);
      slv_len_q.push_back(int'(axi_arlen));
    end
    ar_low_seen = !axi_arvalid;
    r_hs_seen   = axi_rvalid && axi_rready;
    if (r_hs_seen && axi_rresp != OKAY)
      exp_error = 1'b1;
  endtask

  // Slave outputs for the next cycle
  task automatic drive_slave();
    if (r_hs_seen) begin
      beat_shown = 1'b0;
      if (beat_idx == slv_len_q[0]) begin
        slv_addr_q.delete(0);
        slv_len_q.delete(0);
        beat_idx = 0;
      end else begin
        beat_idx++;
      end
    end
    axi_arready = (rand_bits(2) != 0);
    // Data only once the address phase has gone quiet
    if (!beat_shown && slv_addr_q.size() > 0 && ar_low_seen && rand_bits(2) != 0) begin
      beat_shown = 1'b1;
      axi_rdata  = beat_data(slv_addr_q[0] + ADDR_W'(beat_idx * 64));
      axi_rlast  = (beat_idx == slv_len_q[0]);
      axi_rresp  = (inject_errors && rand_bits(5) == 0) ? SLVERR : OKAY;
    end
    axi_rvalid = beat_shown;
  endtask

  task automatic tick();
    @(negedge core_clk);
    watch_bus();
    @(posedge core_clk);
    #1;
    drive_slave();
  endtask

  task automatic reg_write(input reg_addr_e addr, input logic [31:0] data);
    reg_wr_en = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    tick();
    reg_wr_en = 1'b0;
  endtask

  // rdata lands one cycle after the strobe
  task automatic reg_read(input reg_addr_e addr, output logic [31:0] data);
    reg_rd_en = 1'b1;
    reg_addr  = addr;
    tick();
    reg_rd_en = 1'b0;
    data      = reg_rdata;
  endtask

  // --------------------------------------------------
  // One fetch from start to status check
  // --------------------------------------------------
  task automatic run_fetch(input logic [ADDR_W-1:0] base, input int count,
                           input logic restart);
    logic [31:0] status;
    logic [31:0] value;
    load_model(base, count);
    inject_errors = (rand_bits(2) == 0);
    reg_write(ADDR_LO, base[31:0]);
    reg_write(ADDR_HI, 32'(base[ADDR_W-1:32]));
    reg_write(COUNT, 32'(count));
    reg_write(CTRL, 32'h1);
    if (restart) begin
      repeat (3) tick();
      reg_write(CTRL, 32'h1);
    end
    status = '0;
    while (!status[1])
      reg_read(STATUS, status);
    // Room for any stray burst after done
    repeat (4) tick();
    reg_read(STATUS, status);
    if (status[2:0] !== {exp_error, 2'b10})
      report_mismatch("status", {exp_error, 2'b10}, status[2:0]);
    if (exp_addr_q.size() != 0)
      report_failure($sformatf("%0d expected bursts never issued", exp_addr_q.size()));
    if (ar_beat_total != exp_beats)
      report_mismatch("burst beat total", exp_beats, ar_beat_total);
    if (count == 0 && arvalid_seen)
      report_failure("arvalid raised for a zero byte count");
    reg_read(CHECKSUM, value);
    if (value !== exp_checksum)
      report_mismatch("checksum", exp_checksum, value);
    reg_read(BEATS, value);
    if (value != 32'(exp_beats))
      report_mismatch("beats", exp_beats, value);
  endtask

  // Hang guard
  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge core_clk);
      cycles++;
    end
    $display("timeout: run still busy after %0d cycles, %0d mismatches, %0d other errors",
             CYCLE_LIMIT, mismatches, failures);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    reg_wr_en   = 1'b0;
    reg_rd_en   = 1'b0;
    reg_addr    = CTRL;
    reg_wdata   = '0;
    axi_arready = 1'b0;
    axi_rdata   = '0;
    axi_rlast   = 1'b0;
    axi_rvalid  = 1'b0;
    axi_rresp   = OKAY;
    lfsr        = 16'd19441;
    mismatches  = 0;
    failures    = 0;
    beat_idx    = 0;
    beat_shown  = 1'b0;
    r_hs_seen   = 1'b0;
    ar_low_seen = 1'b0;
    ar_stalled  = 1'b0;
    wait (resetn === 1'b1);
    @(posedge core_clk);
    #1;
    test_name = "restart_busy";
    run_fetch(random_address(), 4000 + int'(rand_bits(14) % 16000), 1'b1);
    // Zero count after real traffic so its clear shows
    test_name = "zero_count";
    run_fetch(random_address(), 0, 1'b0);
    for (int i = 0; i < NUM_FETCHES - 2; i++) begin
      test_name = $sformatf("random_%0d", i);
      run_fetch(random_address(), int'(rand_bits(15) % 20001), 1'b0);
    end
    $display("check summary: %0d mismatches, %0d other errors", mismatches, failures);
    if (mismatches == 0 && failures == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+include
hdl/fetch_axi_pkg.sv
hdl/fetch_ctrl_pkg.sv
hdl/fetch_if.sv
hdl/axi_read_master.sv
hdl/fetch_regs.sv
hdl/fetch_checksum.sv
hdl/fetch_subsystem.sv
verification/tb_clock_gen.sv
verification/tb_fetch_subsystem.sv

// ==== Makefile ====
# Verilator build and run of the fetch subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_fetch_subsystem
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
